/* run_sim.sh */
#!/bin/bash
# Build and run the testbench with Verilator, then look for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_tl_fifo \
  -f tl_fifo.f -o sim_tl_fifo \
  && ./obj_dir/sim_tl_fifo +verilator+error+limit+100 > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }

cat sim.log
grep -q "^Simulation PASSED$" sim.log && exit 0 || exit 1

/* tb_tl_fifo.sv */
`timescale 1ns/10ps

module tb_tl_fifo;

  import tl_fifo_pkg::*;

  typedef enum logic [1:0] {
    REQ,
    LAT,
    DRAIN
  } kind_e;

  // One table row holds a request with its expected response, a latency write or a drain.
  typedef struct packed {
    kind_e                                kind;
    logic                                 bp;
    logic                                 stall;
    tl_a_host_t                           a;
    tl_d_op_e                             exp_op;
    logic [MaxBurstLen-1:0][DataWidth-1:0] exp_data;
  } entry_t;

  logic       clk_i;
  logic       rst_ni;
  logic       host_a_valid_i;
  logic       host_a_ready_o;
  tl_a_host_t host_a_i;
  logic       host_d_valid_o;
  logic       host_d_ready_i;
  tl_d_host_t host_d_o;
  lat_cfg_t   lat_cfg_i;

  entry_t     table_q[$];
  logic       bp_mode = 1'b0;
  logic       bp_next = 1'b0;
  integer     seed = 92;
  int         tb_err_cnt = 0;
  int         stall_cnt = 0;
  int         cycle_cnt = 0;
  int         cycle_limit = 1000000;

  tl_fifo_top uut (
    .clk_i,
    .rst_ni,
    .host_a_valid_i,
    .host_a_ready_o,
    .host_a_i,
    .host_d_valid_o,
    .host_d_ready_i,
    .host_d_o,
    .lat_cfg_i
  );

  tl_fifo_monitor u_monitor (
    .clk_i,
    .rst_ni,
    .d_valid_i (host_d_valid_o),
    .d_ready_i (host_d_ready_i),
    .d_i       (host_d_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////
  // Table building
  ////////////////////////////////////////////////////////////////////////

  // Gets above one word split into 32-bit beats.
  function automatic int beats_for(input tl_a_op_e op, input logic [2:0] size);
    if (op != Get || size <= 3'd2) begin
      return 1;
    end
    return 1 << (size - 3'd2);
  endfunction

  task automatic add_get(input logic [2:0] size, input logic [1:0] src, input logic [7:0] addr,
                         input logic [127:0] words);
    entry_t e;
    e = '0;
    e.kind = REQ;
    e.bp = bp_next;
    e.a = '{opcode: Get, size: size, source: src, address: addr, mask: 4'hF, data: '0};
    e.exp_op = AccessAckData;
    e.exp_data = words;
    table_q.push_back(e);
  endtask

  task automatic add_put(input logic [1:0] src, input logic [7:0] addr, input logic [31:0] data);
    entry_t e;
    e = '0;
    e.kind = REQ;
    e.bp = bp_next;
    e.a = '{opcode: PutFullData, size: 3'd2, source: src, address: addr, mask: 4'hF, data: data};
    e.exp_op = AccessAck;
    table_q.push_back(e);
  endtask

  task automatic add_lat(input logic [1:0] slot, input logic [3:0] lat);
    entry_t e;
    e = '0;
    e.kind = LAT;
    e.a.source = slot;
    e.a.data = {28'd0, lat};
    table_q.push_back(e);
  endtask

  task automatic add_drain(input logic stall);
    entry_t e;
    e = '0;
    e.kind = DRAIN;
    e.bp = bp_next;
    e.stall = stall;
    table_q.push_back(e);
  endtask

  task automatic build_table();
    // Single Get.
    add_get(3'd2, 2'd1, 8'h10, {96'd0, 32'hA500_0004});
    add_drain(1'b0);
    // Out-of-order latencies.
    add_lat(2'd0, 4'd12);
    add_lat(2'd1, 4'd2);
    add_lat(2'd2, 4'd6);
    add_lat(2'd3, 4'd1);
    add_get(3'd2, 2'd3, 8'h20, {96'd0, 32'hA500_0008});
    add_get(3'd2, 2'd0, 8'h24, {96'd0, 32'hA500_0009});
    add_get(3'd2, 2'd2, 8'h28, {96'd0, 32'hA500_000A});
    add_get(3'd2, 2'd1, 8'h2C, {96'd0, 32'hA500_000B});
    add_drain(1'b0);
    // Burst Get mixed with single beats.
    add_get(3'd4, 2'd0, 8'h40, {32'hA500_0013, 32'hA500_0012, 32'hA500_0011, 32'hA500_0010});
    add_get(3'd2, 2'd1, 8'h04, {96'd0, 32'hA500_0001});
    add_get(3'd2, 2'd2, 8'h08, {96'd0, 32'hA500_0002});
    add_drain(1'b0);
    // Put, then Get of the same word.
    add_put(2'd3, 8'h30, 32'hDEAD_BEEF);
    add_drain(1'b0);
    add_get(3'd2, 2'd3, 8'h30, {96'd0, 32'hDEAD_BEEF});
    add_drain(1'b0);
    // All slots busy, the fifth request has to wait.
    for (int i = 0; i < NumTracker; i++) begin
      add_lat(2'(i), 4'd15);
    end
    for (int i = 0; i < 5; i++) begin
      add_get(3'd2, 2'(i), 8'(4 * i), {96'd0, 32'hA500_0000 + 32'(i)});
    end
    add_drain(1'b1);
    // Random back-pressure on host D.
    add_lat(2'd0, 4'd3);
    add_lat(2'd1, 4'd1);
    add_lat(2'd2, 4'd4);
    add_lat(2'd3, 4'd2);
    bp_next = 1'b1;
    add_get(3'd4, 2'd0, 8'h80, {32'hA500_0023, 32'hA500_0022, 32'hA500_0021, 32'hA500_0020});
    add_get(3'd3, 2'd1, 8'h90, {64'd0, 32'hA500_0025, 32'hA500_0024});
    add_get(3'd2, 2'd2, 8'h30, {96'd0, 32'hDEAD_BEEF});
    add_get(3'd4, 2'd3, 8'hF0, {32'hA500_003F, 32'hA500_003E, 32'hA500_003D, 32'hA500_003C});
    add_put(2'd0, 8'hA0, 32'h1234_5678);
    add_drain(1'b0);
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    #1;
    host_d_ready_i <= bp_mode ? 1'($random(seed)) : 1'b1;
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout after %0d cycles with %0d response beats outstanding",
               cycle_cnt, u_monitor.pending());
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    entry_t e;
    logic   acc;
    int     total;
    rst_ni         = 1'b0;
    host_a_valid_i = 1'b0;
    host_a_i       = '0;
    host_d_ready_i = 1'b1;
    lat_cfg_i      = '0;
    build_table();
    cycle_limit = table_q.size() * (15 + 4) + 200;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    foreach (table_q[i]) begin
      e = table_q[i];
      bp_mode = e.bp;
      case (e.kind)
        LAT: begin
          lat_cfg_i = '{wr_en: 1'b1, slot: e.a.source, latency: e.a.data[3:0]};
          @(posedge clk_i);
          #1;
          lat_cfg_i.wr_en = 1'b0;
        end
        REQ: begin
          host_a_valid_i = 1'b1;
          host_a_i = e.a;
          for (int b = 0; b < beats_for(e.a.opcode, e.a.size); b++) begin
            u_monitor.push_beat(e.exp_op, e.a.size, e.a.source, e.exp_data[b]);
          end
          // Ready is settled by the falling edge.
          do begin
            @(negedge clk_i);
            acc = host_a_ready_o;
            if (!acc) begin
              stall_cnt++;
            end
            @(posedge clk_i);
            #1;
          end while (!acc);
          host_a_valid_i = 1'b0;
        end
        default: begin
          while (u_monitor.pending() != 0) begin
            @(posedge clk_i);
            #1;
          end
          if (e.stall && stall_cnt == 0) begin
            $display("Request with all slots busy was accepted without waiting");
            tb_err_cnt++;
          end
          stall_cnt = 0;
        end
      endcase
    end

    repeat (5) @(posedge clk_i);
    total = u_monitor.mismatch_cnt + u_monitor.unexpected_cnt + tb_err_cnt
            + uut.u_converter.u_checker.fail_cnt;
    $display("Errors: %0d mismatches, %0d unexpected beats, %0d stimulus, %0d assertions",
             u_monitor.mismatch_cnt, u_monitor.unexpected_cnt, tb_err_cnt,
             uut.u_converter.u_checker.fail_cnt);
    if (total == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* tl_burst_tracker.sv */
`timescale 1ns/10ps

module tl_burst_tracker (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,

  input  logic                                   a_valid_i,
  input  logic                                   a_ready_i,
  input  tl_fifo_pkg::tl_a_op_e                  a_op_i,
  input  logic [tl_fifo_pkg::SizeWidth-1:0]      a_size_i,

  input  logic                                   d_valid_i,
  input  logic                                   d_ready_i,
  input  tl_fifo_pkg::tl_d_op_e                  d_op_i,
  input  logic [tl_fifo_pkg::SizeWidth-1:0]      d_size_i,

  output logic                                   a_first_o,
  output logic                                   d_last_o,
  output logic [tl_fifo_pkg::BurstIdxWidth-1:0]  d_idx_o
);

  import tl_fifo_pkg::*;

  logic [BurstIdxWidth-1:0] a_cnt_q;
  logic [BurstIdxWidth-1:0] d_cnt_q;
  logic [BurstIdxWidth-1:0] a_last_idx;
  logic [BurstIdxWidth-1:0] d_last_idx;
  logic                     a_last;

  // Puts carry data on A, AccessAckData carries data on D.
  assign a_last_idx = last_beat_idx(a_op_i == PutFullData, a_size_i);
  assign d_last_idx = last_beat_idx(d_op_i == AccessAckData, d_size_i);

  assign a_last    = (a_cnt_q == a_last_idx);
  assign a_first_o = (a_cnt_q == '0);
  assign d_last_o  = (d_cnt_q == d_last_idx);
  assign d_idx_o   = d_cnt_q;

  //////////////////////////////////////////////////////////////////////
  // Beat counters
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      a_cnt_q <= '0;
      d_cnt_q <= '0;
    end else begin
      if (a_valid_i && a_ready_i) begin
        a_cnt_q <= a_last ? '0 : a_cnt_q + BurstIdxWidth'(1);
      end
      if (d_valid_i && d_ready_i) begin
        // Wrap back to zero after the final beat.
        d_cnt_q <= d_last_o ? '0 : d_cnt_q + BurstIdxWidth'(1);
      end
    end
  end

endmodule

/* tl_fifo.f */
tl_fifo_pkg.sv
tl_burst_tracker.sv
tl_fifo_converter.sv
tl_latency_regs.sv
tl_ooo_memory.sv
tl_fifo_top.sv
tl_fifo_monitor.sv
tl_fifo_checker.sv
tb_tl_fifo.sv

/* tl_fifo_checker.sv */
`timescale 1ns/10ps

module tl_fifo_checker (
  input logic                                  clk_i,
  input logic                                  rst_ni,
  input logic                                  host_a_valid_i,
  input logic                                  host_a_ready_o,
  input logic                                  host_d_valid_o,
  input logic                                  host_d_ready_i,
  input tl_fifo_pkg::tl_d_host_t               host_d_o,
  input logic                                  host_a_first,
  input logic                                  host_d_last
);

  import tl_fifo_pkg::*;

  int fail_cnt = 0;

  // Responses still owed to the host, counted from the host handshakes.
  logic [2:0] owed_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      owed_q <= '0;
    end else begin
      owed_q <= owed_q
                + 3'(host_a_valid_i && host_a_ready_o && host_a_first)
                - 3'(host_d_valid_o && host_d_ready_i && host_d_last);
    end
  end

  // Host D response holds under back-pressure.
  d_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    host_d_valid_o && !host_d_ready_i |=> host_d_valid_o && $stable(host_d_o))
    else begin
      $error("host D response changed while stalled");
      fail_cnt++;
    end

  // With every slot owed a response, no new request may start.
  no_alloc_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    host_a_valid_i && host_a_ready_o && host_a_first |-> owed_q < 3'(NumTracker))
    else begin
      $error("first A beat accepted while all slots were occupied");
      fail_cnt++;
    end

endmodule

bind tl_fifo_converter tl_fifo_checker u_checker (
  .clk_i,
  .rst_ni,
  .host_a_valid_i,
  .host_a_ready_o,
  .host_d_valid_o,
  .host_d_ready_i,
  .host_d_o,
  .host_a_first,
  .host_d_last
);

/* tl_fifo_converter.sv */
`timescale 1ns/10ps

module tl_fifo_converter (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  input  logic                    host_a_valid_i,
  output logic                    host_a_ready_o,
  input  tl_fifo_pkg::tl_a_host_t host_a_i,

  output logic                    host_d_valid_o,
  input  logic                    host_d_ready_i,
  output tl_fifo_pkg::tl_d_host_t host_d_o,

  output logic                    dev_a_valid_o,
  input  logic                    dev_a_ready_i,
  output tl_fifo_pkg::tl_a_dev_t  dev_a_o,

  input  logic                    dev_d_valid_i,
  output logic                    dev_d_ready_o,
  input  tl_fifo_pkg::tl_d_dev_t  dev_d_i
);

  import tl_fifo_pkg::*;

  // Response fields captured on the last device beat.
  typedef struct packed {
    tl_d_op_e             opcode;
    logic [SizeWidth-1:0] size;
  } d_ctrl_t;

  //////////////////////////////////////////////////////////////////////
  // Beat tracking on both links
  //////////////////////////////////////////////////////////////////////

  logic                     host_a_first;
  logic                     host_d_last;
  logic [BurstIdxWidth-1:0] host_d_idx;
  logic                     device_d_last;
  logic [BurstIdxWidth-1:0] device_d_idx;

  tl_burst_tracker host_burst_tracker (
    .clk_i,
    .rst_ni,
    .a_valid_i (host_a_valid_i),
    .a_ready_i (host_a_ready_o),
    .a_op_i    (host_a_i.opcode),
    .a_size_i  (host_a_i.size),
    .d_valid_i (host_d_valid_o),
    .d_ready_i (host_d_ready_i),
    .d_op_i    (host_d_o.opcode),
    .d_size_i  (host_d_o.size),
    .a_first_o (host_a_first),
    .d_last_o  (host_d_last),
    .d_idx_o   (host_d_idx)
  );

  tl_burst_tracker device_burst_tracker (
    .clk_i,
    .rst_ni,
    .a_valid_i (dev_a_valid_o),
    .a_ready_i (dev_a_ready_i),
    .a_op_i    (dev_a_o.opcode),
    .a_size_i  (dev_a_o.size),
    .d_valid_i (dev_d_valid_i),
    .d_ready_i (dev_d_ready_o),
    .d_op_i    (dev_d_i.opcode),
    .d_size_i  (dev_d_i.size),
    .a_first_o (),
    .d_last_o  (device_d_last),
    .d_idx_o   (device_d_idx)
  );

  //////////////////////////////////////////////////////////////////////
  // Slot ring and response buffer
  //////////////////////////////////////////////////////////////////////

  logic [NumTracker-1:0]                  slot_valid_q, slot_valid_d;
  logic [NumTracker-1:0]                  slot_ready_q, slot_ready_d;
  logic [NumTracker-1:0][SourceWidth-1:0] slot_source_q;
  d_ctrl_t [NumTracker-1:0]               slot_ctrl_q;
  logic [NumTracker-1:0][MaxBurstLen-1:0][DataWidth-1:0] slot_data_q;

  logic [TrackerWidth-1:0] a_ptr_q, a_ptr_d;
  logic [TrackerWidth-1:0] d_ptr_q, d_ptr_d;
  logic                    slot_free;
  logic                    a_alloc;

  // A first beat needs a free slot; later beats ride on the slot already taken.
  assign slot_free = !slot_valid_q[a_ptr_q];
  assign a_alloc   = host_a_valid_i && host_a_ready_o && host_a_first;

  always_comb begin
    slot_valid_d = slot_valid_q;
    slot_ready_d = slot_ready_q;
    a_ptr_d      = a_ptr_q;
    d_ptr_d      = d_ptr_q;

    if (dev_d_valid_i && dev_d_ready_o && device_d_last) begin
      slot_ready_d[dev_d_i.source] = 1'b1;
    end

    // Release the oldest slot once its last beat reaches the host.
    if (host_d_valid_o && host_d_ready_i && host_d_last) begin
      slot_valid_d[d_ptr_q] = 1'b0;
      slot_ready_d[d_ptr_q] = 1'b0;
      d_ptr_d               = d_ptr_q + TrackerWidth'(1);
    end

    if (a_alloc) begin
      slot_valid_d[a_ptr_q] = 1'b1;
      a_ptr_d               = a_ptr_q + TrackerWidth'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_valid_q <= '0;
      slot_ready_q <= '0;
      a_ptr_q      <= '0;
      d_ptr_q      <= '0;
    end else begin
      slot_valid_q <= slot_valid_d;
      slot_ready_q <= slot_ready_d;
      a_ptr_q      <= a_ptr_d;
      d_ptr_q      <= d_ptr_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_alloc) begin
      slot_source_q[a_ptr_q] <= host_a_i.source;
    end
    if (dev_d_valid_i && dev_d_ready_o) begin
      slot_data_q[dev_d_i.source][device_d_idx] <= dev_d_i.data;
      if (device_d_last) begin
        slot_ctrl_q[dev_d_i.source] <= '{opcode: dev_d_i.opcode, size: dev_d_i.size};
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Channel outputs
  //////////////////////////////////////////////////////////////////////

  assign host_a_ready_o = (!host_a_first || slot_free) && dev_a_ready_i;
  assign dev_a_valid_o  = host_a_valid_i && (!host_a_first || slot_free);

  always_comb begin
    dev_a_o         = '0;
    dev_a_o.opcode  = host_a_i.opcode;
    dev_a_o.size    = host_a_i.size;
    dev_a_o.source  = a_ptr_q;
    dev_a_o.address = host_a_i.address;
    dev_a_o.mask    = host_a_i.mask;
    dev_a_o.data    = host_a_i.data;
  end

  // Device responses are always taken into the buffer.
  assign dev_d_ready_o = 1'b1;

  assign host_d_valid_o  = slot_ready_q[d_ptr_q];
  assign host_d_o.opcode = slot_ctrl_q[d_ptr_q].opcode;
  assign host_d_o.size   = slot_ctrl_q[d_ptr_q].size;
  assign host_d_o.source = slot_source_q[d_ptr_q];
  assign host_d_o.data   = slot_data_q[d_ptr_q][host_d_idx];

endmodule

/* tl_fifo_monitor.sv */
`timescale 1ns/10ps

module tl_fifo_monitor (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    d_valid_i,
  input  logic                    d_ready_i,
  input  tl_fifo_pkg::tl_d_host_t d_i
);

  import tl_fifo_pkg::*;

  // One expected host D beat.
  typedef struct packed {
    tl_d_op_e               opcode;
    logic [SizeWidth-1:0]   size;
    logic [SourceWidth-1:0] source;
    logic [DataWidth-1:0]   data;
  } exp_beat_t;

  exp_beat_t exp_q[$];
  int        mismatch_cnt = 0;
  int        unexpected_cnt = 0;

  task automatic push_beat(input tl_d_op_e op, input logic [SizeWidth-1:0] size,
                           input logic [SourceWidth-1:0] src,
                           input logic [DataWidth-1:0] data);
    exp_q.push_back('{opcode: op, size: size, source: src, data: data});
  endtask

  function automatic int pending();
    return exp_q.size();
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Beat comparison
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    exp_beat_t exp;
    if (rst_ni && d_valid_i && d_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("Host D beat at %0t arrived with no request waiting for it", $time);
        unexpected_cnt++;
      end else begin
        exp = exp_q.pop_front();
        if (d_i.opcode != exp.opcode) begin
          $display("[ERROR] %0t host_d_o.opcode: got %0d, expected %0d",
                   $time, d_i.opcode, exp.opcode);
          mismatch_cnt++;
        end
        if (d_i.size != exp.size) begin
          $display("[ERROR] %0t host_d_o.size: got %0d, expected %0d",
                   $time, d_i.size, exp.size);
          mismatch_cnt++;
        end
        if (d_i.source != exp.source) begin
          $display("[ERROR] %0t host_d_o.source: got %0d, expected %0d",
                   $time, d_i.source, exp.source);
          mismatch_cnt++;
        end
        if (d_i.data != exp.data) begin
          $display("[ERROR] %0t host_d_o.data: got %h, expected %h",
                   $time, d_i.data, exp.data);
          mismatch_cnt++;
        end
      end
    end
  end

endmodule

/* tl_fifo_pkg.sv */
package tl_fifo_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned DataWidth     = 32;
  localparam int unsigned MaskWidth     = DataWidth / 8;
  localparam int unsigned AddrWidth     = 8;
  localparam int unsigned SourceWidth   = 2;
  localparam int unsigned TrackerWidth  = 2;
  localparam int unsigned NumTracker    = 4;
  localparam int unsigned SizeWidth     = 3;
  localparam int unsigned MaxSize       = 4;
  localparam int unsigned MaxBurstLen   = 4;
  localparam int unsigned BurstIdxWidth = 2;
  localparam int unsigned LatWidth      = 4;
  localparam int unsigned MemWords      = 64;

  // Log2 of the bytes in one beat, and the word index width of the memory.
  localparam int unsigned BeatSize      = $clog2(DataWidth / 8);
  localparam int unsigned MemIdxWidth   = $clog2(MemWords);

  //////////////////////////////////////////////////////////////////////
  // Opcodes and channel payloads
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    PutFullData = 3'd0,
    Get         = 3'd4
  } tl_a_op_e;

  typedef enum logic [2:0] {
    AccessAck     = 3'd0,
    AccessAckData = 3'd1
  } tl_d_op_e;

  typedef struct packed {
    tl_a_op_e               opcode;
    logic [SizeWidth-1:0]   size;
    logic [SourceWidth-1:0] source;
    logic [AddrWidth-1:0]   address;
    logic [MaskWidth-1:0]   mask;
    logic [DataWidth-1:0]   data;
  } tl_a_host_t;

  typedef struct packed {
    tl_a_op_e                opcode;
    logic [SizeWidth-1:0]    size;
    logic [TrackerWidth-1:0] source;
    logic [AddrWidth-1:0]    address;
    logic [MaskWidth-1:0]    mask;
    logic [DataWidth-1:0]    data;
  } tl_a_dev_t;

  typedef struct packed {
    tl_d_op_e               opcode;
    logic [SizeWidth-1:0]   size;
    logic [SourceWidth-1:0] source;
    logic [DataWidth-1:0]   data;
  } tl_d_host_t;

  typedef struct packed {
    tl_d_op_e                opcode;
    logic [SizeWidth-1:0]    size;
    logic [TrackerWidth-1:0] source;
    logic [DataWidth-1:0]    data;
  } tl_d_dev_t;

  // One write to the latency table.
  typedef struct packed {
    logic                    wr_en;
    logic [TrackerWidth-1:0] slot;
    logic [LatWidth-1:0]     latency;
  } lat_cfg_t;

  // Index of the last beat of a message.
  // Only data-carrying messages span more than one beat.
  function automatic logic [BurstIdxWidth-1:0] last_beat_idx(input logic has_data,
                                                             input logic [SizeWidth-1:0] size);
    logic [SizeWidth-1:0] clamped;
    clamped = (size > SizeWidth'(MaxSize)) ? SizeWidth'(MaxSize) : size;
    if (!has_data || clamped <= SizeWidth'(BeatSize)) begin
      return '0;
    end
    return BurstIdxWidth'((1 << (clamped - SizeWidth'(BeatSize))) - 1);
  endfunction

endpackage

/* tl_fifo_top.sv */
`timescale 1ns/10ps

module tl_fifo_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  input  logic                    host_a_valid_i,
  output logic                    host_a_ready_o,
  input  tl_fifo_pkg::tl_a_host_t host_a_i,

  output logic                    host_d_valid_o,
  input  logic                    host_d_ready_i,
  output tl_fifo_pkg::tl_d_host_t host_d_o,

  input  tl_fifo_pkg::lat_cfg_t   lat_cfg_i
);

  import tl_fifo_pkg::*;

  logic                                dev_a_valid;
  logic                                dev_a_ready;
  tl_a_dev_t                           dev_a;
  logic                                dev_d_valid;
  tl_d_dev_t                           dev_d;
  logic [NumTracker-1:0][LatWidth-1:0] lat_table;

  tl_fifo_converter u_converter (
    .clk_i,
    .rst_ni,
    .host_a_valid_i,
    .host_a_ready_o,
    .host_a_i,
    .host_d_valid_o,
    .host_d_ready_i,
    .host_d_o,
    .dev_a_valid_o (dev_a_valid),
    .dev_a_ready_i (dev_a_ready),
    .dev_a_o       (dev_a),
    .dev_d_valid_i (dev_d_valid),
    // The memory sends without waiting for ready.
    .dev_d_ready_o (),
    .dev_d_i       (dev_d)
  );

  tl_ooo_memory u_memory (
    .clk_i,
    .rst_ni,
    .a_valid_i (dev_a_valid),
    .a_ready_o (dev_a_ready),
    .a_i       (dev_a),
    .d_valid_o (dev_d_valid),
    .d_o       (dev_d),
    .lat_i     (lat_table)
  );

  tl_latency_regs u_latency_regs (
    .clk_i,
    .rst_ni,
    .cfg_i (lat_cfg_i),
    .lat_o (lat_table)
  );

endmodule

/* tl_latency_regs.sv */
`timescale 1ns/10ps

module tl_latency_regs (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  input  tl_fifo_pkg::lat_cfg_t cfg_i,
  output logic [tl_fifo_pkg::NumTracker-1:0][tl_fifo_pkg::LatWidth-1:0] lat_o
);

  import tl_fifo_pkg::*;

  logic [NumTracker-1:0][LatWidth-1:0] lat_q;
  logic [LatWidth-1:0]                 wr_lat;

  // A latency of zero is raised to one cycle.
  assign wr_lat = (cfg_i.latency == '0) ? LatWidth'(1) : cfg_i.latency;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumTracker; i++) begin
        lat_q[i] <= LatWidth'(1);
      end
    end else if (cfg_i.wr_en) begin
      lat_q[cfg_i.slot] <= wr_lat;
    end
  end

  assign lat_o = lat_q;

endmodule

/* tl_ooo_memory.sv */
`timescale 1ns/10ps

module tl_ooo_memory (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  logic                   a_valid_i,
  output logic                   a_ready_o,
  input  tl_fifo_pkg::tl_a_dev_t a_i,

  output logic                   d_valid_o,
  output tl_fifo_pkg::tl_d_dev_t d_o,

  input  logic [tl_fifo_pkg::NumTracker-1:0][tl_fifo_pkg::LatWidth-1:0] lat_i
);

  import tl_fifo_pkg::*;

  typedef enum logic {
    IDLE,
    BURST
  } mem_state_e;

  // One pending request per slot.
  typedef struct packed {
    logic                   valid;
    tl_a_op_e               opcode;
    logic [SizeWidth-1:0]   size;
    logic [MemIdxWidth-1:0] word;
    logic [LatWidth-1:0]    count;
  } pend_t;

  logic [DataWidth-1:0]     mem_q [MemWords];
  pend_t [NumTracker-1:0]   pend_q;

  mem_state_e               state_q, state_d;
  logic [TrackerWidth-1:0]  cur_q, cur_d;
  logic [BurstIdxWidth-1:0] beat_q, beat_d;

  logic                     any_eligible;
  logic [TrackerWidth-1:0]  sel_slot;
  logic [TrackerWidth-1:0]  slot;
  logic [BurstIdxWidth-1:0] beat;
  logic [BurstIdxWidth-1:0] last_beat;
  logic                     d_last;
  logic [MemIdxWidth-1:0]   rd_word;
  logic [MemIdxWidth-1:0]   wr_word;

  assign a_ready_o = 1'b1;
  assign wr_word   = a_i.address[BeatSize +: MemIdxWidth];

  // Lowest eligible slot wins.
  always_comb begin
    any_eligible = 1'b0;
    sel_slot     = '0;
    for (int i = NumTracker - 1; i >= 0; i--) begin
      if (pend_q[i].valid && pend_q[i].count == '0) begin
        any_eligible = 1'b1;
        sel_slot     = TrackerWidth'(i);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Responder
  //////////////////////////////////////////////////////////////////////

  // The first beat goes out straight from IDLE; BURST covers the rest.
  assign slot      = (state_q == BURST) ? cur_q : sel_slot;
  assign beat      = (state_q == BURST) ? beat_q : '0;
  assign last_beat = last_beat_idx(pend_q[slot].opcode == Get, pend_q[slot].size);
  assign d_valid_o = (state_q == BURST) || any_eligible;
  assign d_last    = d_valid_o && (beat == last_beat);
  assign rd_word   = pend_q[slot].word + MemIdxWidth'(beat);

  assign d_o.opcode = (pend_q[slot].opcode == Get) ? AccessAckData : AccessAck;
  assign d_o.size   = pend_q[slot].size;
  assign d_o.source = slot;
  assign d_o.data   = (pend_q[slot].opcode == Get) ? mem_q[rd_word] : '0;

  always_comb begin
    state_d = state_q;
    cur_d   = cur_q;
    beat_d  = beat_q;
    case (state_q)
      IDLE: begin
        if (any_eligible && !d_last) begin
          state_d = BURST;
          cur_d   = sel_slot;
          beat_d  = BurstIdxWidth'(1);
        end
      end
      BURST: begin
        if (d_last) begin
          state_d = IDLE;
        end else begin
          beat_d = beat_q + BurstIdxWidth'(1);
        end
      end
      default: state_d = IDLE;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Storage and pending slots
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int w = 0; w < MemWords; w++) begin
        mem_q[w] <= 32'hA500_0000 + DataWidth'(w);
      end
      pend_q  <= '0;
      state_q <= IDLE;
      cur_q   <= '0;
      beat_q  <= '0;
    end else begin
      for (int i = 0; i < NumTracker; i++) begin
        if (pend_q[i].valid && pend_q[i].count != '0) begin
          pend_q[i].count <= pend_q[i].count - LatWidth'(1);
        end
      end
      if (d_last) begin
        pend_q[slot].valid <= 1'b0;
      end
      if (a_valid_i && a_ready_o) begin
        pend_q[a_i.source] <= '{valid: 1'b1, opcode: a_i.opcode, size: a_i.size,
                                word: wr_word, count: lat_i[a_i.source]};
        // Puts land in memory at acceptance.
        if (a_i.opcode == PutFullData) begin
          for (int b = 0; b < MaskWidth; b++) begin
            if (a_i.mask[b]) begin
              mem_q[wr_word][8*b +: 8] <= a_i.data[8*b +: 8];
            end
          end
        end
      end
      state_q <= state_d;
      cur_q   <= cur_d;
      beat_q  <= beat_d;
    end
  end

endmodule
